// ==== Makefile ====
SIM      ?= verilator
FLAGS    ?= --binary --timing --timescale 1ns/100ps -j 0
TOP      ?= tb_astro
FILELIST ?= src.f
BUILD    ?= obj_dir
LOG      ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

# Pass only when the log holds the pass message
run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== common/astro_macros.svh ====
// Widths, game codes and DIP bit positions for the cabinet logic
// Game codes match the byte loaded at download time; 0 selects no game
`ifndef ASTRO_MACROS_SVH
`define ASTRO_MACROS_SVH

// ==================================================
// Data widths
// ==================================================
// One audio channel word
`define AUDIO_W 16
// Mix sum, one bit wider to catch overflow
`define MIX_W 17
// Ranking lamps on the external latch
`define LAMP_N 8
`define LAMP_ADDR_W 3

// ==================================================
// Game code byte values
// ==================================================
`define GAME_EBASE 8'd1
`define GAME_SEAWOLF2 8'd2
`define GAME_SPACEZAP 8'd3
`define GAME_GORF 8'd4
`define GAME_WOW 8'd5
`define GAME_ROBBY 8'd6
`define GAME_GORF1 8'd7

// DIP byte fields
// Cabinet speaker mode, Gorf only
`define DIP_CAB_BIT 0
// Set keeps left/right in natural order
`define DIP_ORDER_BIT 1

// Lamp divider bit, one tick per 4 clocks
`define LAMP_TICK_BIT 1

`endif

// ==== common/astro_pkg.sv ====
// Shared types for game flags, stereo audio and lamp latch commands
// Audio words are raw bits; signedness depends on the selected source
`include "astro_macros.svh"

package astro_pkg;

	// ==================================================
	// Game selection
	// ==================================================
	// One-hot game bits plus the derived audio mode bits
	typedef struct packed {
		logic ebase;
		logic seawolf2;
		logic spacezap;
		// Also set for Gorf program 1
		logic gorf;
		logic wow;
		logic robby;
		logic gorf1;
		// Two sound chips fitted
		logic stereo;
		// Samples only, no sound chip
		logic only_samples;
		// Samples mixed with the sound chip
		logic plus_samples;
	} game_flags_t;

	// ==================================================
	// Audio
	// ==================================================
	// Left and right words of one stereo sample
	typedef struct packed {
		logic [`AUDIO_W-1:0] left;
		logic [`AUDIO_W-1:0] right;
	} stereo_pcm_t;

	// ==================================================
	// Lamp latch
	// ==================================================
	// Addressable latch write, strobe active low
	typedef struct packed {
		logic [`LAMP_ADDR_W-1:0] addr;
		logic data;
		logic wr_n;
	} lamp_cmd_t;

endpackage

// ==== hw/astro_cabinet_top.sv ====
// Cabinet-side top level on a single clock with no back-pressure
// Audio out is two clocks behind the audio inputs
`include "astro_macros.svh"

module astro_cabinet_top (
	input  logic                   i_clk_sys,
	input  logic                   i_reset,
	input  logic                   i_load,
	input  logic [7:0]             i_code,
	input  logic [7:0]             i_dip,
	input  astro_pkg::stereo_pcm_t i_chip,
	input  astro_pkg::stereo_pcm_t i_samp,
	input  logic                   i_speech,
	input  logic [`LAMP_N-1:0]     i_lamps,
	output astro_pkg::stereo_pcm_t o_audio,
	output logic                   o_audio_signed,
	output astro_pkg::lamp_cmd_t   o_lamp
);

	astro_pkg::game_flags_t flags;
	// Mixer and router results, aligned one clock after the inputs
	astro_pkg::stereo_pcm_t mix;
	astro_pkg::stereo_pcm_t cab;

	// ==================================================
	// Game selection
	// ==================================================
	game_config u_game_config (
		.i_clk_sys (i_clk_sys),
		.i_reset   (i_reset),
		.i_load    (i_load),
		.i_code    (i_code),
		.o_flags   (flags)
	);

	// ==================================================
	// Audio path
	// ==================================================
	audio_mixer u_audio_mixer (
		.i_clk_sys (i_clk_sys),
		.i_reset   (i_reset),
		.i_flags   (flags),
		.i_chip    (i_chip),
		.i_samp    (i_samp),
		.o_mix     (mix)
	);

	cabinet_router u_cabinet_router (
		.i_clk_sys (i_clk_sys),
		.i_reset   (i_reset),
		.i_chip    (i_chip),
		.i_samp    (i_samp),
		.i_speech  (i_speech),
		.o_cab     (cab)
	);

	output_select u_output_select (
		.i_clk_sys      (i_clk_sys),
		.i_reset        (i_reset),
		.i_flags        (flags),
		.i_dip          (i_dip),
		.i_chip         (i_chip),
		.i_samp         (i_samp),
		.i_mix          (mix),
		.i_cab          (cab),
		.o_audio        (o_audio),
		.o_audio_signed (o_audio_signed)
	);

	// Ranking lamps
	lamp_serializer u_lamp_serializer (
		.i_clk_sys (i_clk_sys),
		.i_reset   (i_reset),
		.i_flags   (flags),
		.i_lamps   (i_lamps),
		.o_lamp    (o_lamp)
	);

endmodule

// ==== hw/audio/audio_mixer.sv ====
// Chip audio is unsigned, samples are signed; output is signed and clipped
// One clock of latency
`include "astro_macros.svh"

module audio_mixer (
	input  logic                   i_clk_sys,
	input  logic                   i_reset,
	input  astro_pkg::game_flags_t i_flags,
	input  astro_pkg::stereo_pcm_t i_chip,
	input  astro_pkg::stereo_pcm_t i_samp,
	output astro_pkg::stereo_pcm_t o_mix
);

	// Registered wide sums
	logic [`MIX_W-1:0] sum_l_q;
	logic [`MIX_W-1:0] sum_r_q;

	// Scale both sources and add them in one channel
	function automatic logic [`MIX_W-1:0] mix_sum(
		input logic [`AUDIO_W-1:0] chip,
		input logic [`AUDIO_W-1:0] samp,
		input logic                wow
	);
		logic [`MIX_W-1:0] chip_x;
		logic [`MIX_W-1:0] samp_x;
		// Wow effects are loud, so drop one more bit
		chip_x = wow ? {3'b000, chip[`AUDIO_W-1:2]} : {2'b00, chip[`AUDIO_W-1:1]};
		// Halve samples keeping the sign
		samp_x = {samp[`AUDIO_W-1], samp[`AUDIO_W-1], samp[`AUDIO_W-1:1]};
		return chip_x + samp_x;
	endfunction

	// Saturate when the top two sum bits disagree
	function automatic logic [`AUDIO_W-1:0] clip(input logic [`MIX_W-1:0] s);
		logic ovf;
		ovf = s[`MIX_W-1] ^ s[`MIX_W-2];
		// Negative overflow gives 8000, positive gives 7FFF
		return ovf ? {s[`MIX_W-1], {(`AUDIO_W-1){~s[`MIX_W-1]}}} : s[`AUDIO_W-1:0];
	endfunction

	// ==================================================
	// Sum register
	// ==================================================
	always_ff @(posedge i_clk_sys or posedge i_reset) begin
		if (i_reset) begin
			sum_l_q <= '0;
			sum_r_q <= '0;
		end else begin
			sum_l_q <= mix_sum(i_chip.left, i_samp.left, i_flags.wow);
			sum_r_q <= mix_sum(i_chip.right, i_samp.right, i_flags.wow);
		end
	end

	// Clip after the register
	assign o_mix.left  = clip(sum_l_q);
	assign o_mix.right = clip(sum_r_q);

endmodule

// ==== hw/audio/cabinet_router.sv ====
// Dedicated-speaker feed for the Gorf cabinet
// One clock of latency; speech select follows the sound board output
`include "astro_macros.svh"

module cabinet_router (
	input  logic                   i_clk_sys,
	input  logic                   i_reset,
	input  astro_pkg::stereo_pcm_t i_chip,
	input  astro_pkg::stereo_pcm_t i_samp,
	input  logic                   i_speech,
	output astro_pkg::stereo_pcm_t o_cab
);

	// Next cabinet feed
	astro_pkg::stereo_pcm_t cab_d;

	// ==================================================
	// Speaker routing
	// ==================================================
	always_comb begin
		// Right speaker carries one sound chip only
		cab_d.right = {1'b0, i_chip.right[`AUDIO_W-1:1]};
		// Left speaker switches between speech and the other chip
		if (i_speech) begin
			cab_d.left = i_samp.left;
		end else begin
			cab_d.left = {1'b0, i_chip.left[`AUDIO_W-1:1]};
		end
	end

	// Output register
	always_ff @(posedge i_clk_sys or posedge i_reset) begin
		if (i_reset) begin
			o_cab <= '0;
		end else begin
			o_cab <= cab_d;
		end
	end

endmodule

// ==== hw/audio/output_select.sv ====
// Final audio source select and channel order; outputs are registered
// Raw inputs are delayed here to line up with mixer and router
`include "astro_macros.svh"

module output_select (
	input  logic                   i_clk_sys,
	input  logic                   i_reset,
	input  astro_pkg::game_flags_t i_flags,
	input  logic [7:0]             i_dip,
	input  astro_pkg::stereo_pcm_t i_chip,
	input  astro_pkg::stereo_pcm_t i_samp,
	input  astro_pkg::stereo_pcm_t i_mix,
	input  astro_pkg::stereo_pcm_t i_cab,
	output astro_pkg::stereo_pcm_t o_audio,
	output logic                   o_audio_signed
);

	// Raw sources, one clock late
	astro_pkg::stereo_pcm_t chip_q;
	astro_pkg::stereo_pcm_t samp_q;
	// Chosen source and its ordered form
	astro_pkg::stereo_pcm_t pick;
	astro_pkg::stereo_pcm_t ordered;
	logic cab_mode;

	always_ff @(posedge i_clk_sys or posedge i_reset) begin
		if (i_reset) begin
			chip_q <= '0;
			samp_q <= '0;
		end else begin
			chip_q <= i_chip;
			samp_q <= i_samp;
		end
	end

	// Cabinet speakers only exist on Gorf
	assign cab_mode = i_flags.gorf & i_dip[`DIP_CAB_BIT];

	// ==================================================
	// Source priority
	// ==================================================
	always_comb begin
		if (cab_mode) begin
			pick = i_cab;
		end else if (i_flags.only_samples) begin
			pick = samp_q;
		end else if (i_flags.plus_samples) begin
			pick = i_mix;
		end else if (i_flags.stereo) begin
			pick = chip_q;
		end else begin
			// Mono board, one chip on both sides
			pick.left  = chip_q.left;
			pick.right = chip_q.left;
		end
		// Clear order bit swaps the speakers
		if (i_dip[`DIP_ORDER_BIT]) begin
			ordered = pick;
		end else begin
			ordered.left  = pick.right;
			ordered.right = pick.left;
		end
	end

	// Output register, signed flag on the same path
	always_ff @(posedge i_clk_sys or posedge i_reset) begin
		if (i_reset) begin
			o_audio        <= '0;
			o_audio_signed <= 1'b0;
		end else begin
			o_audio        <= ordered;
			o_audio_signed <= i_flags.only_samples | i_flags.plus_samples;
		end
	end

endmodule

// ==== hw/game_config.sv ====
// Game flags are valid two clocks after the load edge
// Gorf program 1 sets both gorf and gorf1
`include "astro_macros.svh"

module game_config (
	input  logic                   i_clk_sys,
	input  logic                   i_reset,
	input  logic                   i_load,
	input  logic [7:0]             i_code,
	output astro_pkg::game_flags_t o_flags
);

	// Loaded game byte
	logic [7:0] code_q;
	// Decoded flags before the register
	astro_pkg::game_flags_t flags_d;

	// Code register, written on download
	always_ff @(posedge i_clk_sys or posedge i_reset) begin
		if (i_reset) begin
			code_q <= 8'd0;
		end else if (i_load) begin
			code_q <= i_code;
		end
	end

	// ==================================================
	// Decode
	// ==================================================
	always_comb begin
		flags_d.ebase    = (code_q == `GAME_EBASE);
		flags_d.seawolf2 = (code_q == `GAME_SEAWOLF2);
		flags_d.spacezap = (code_q == `GAME_SPACEZAP);
		flags_d.gorf1    = (code_q == `GAME_GORF1);
		// Program 1 is still Gorf hardware
		flags_d.gorf     = (code_q == `GAME_GORF) || flags_d.gorf1;
		flags_d.wow      = (code_q == `GAME_WOW);
		flags_d.robby    = (code_q == `GAME_ROBBY);
		// Derived audio modes
		flags_d.stereo       = flags_d.gorf | flags_d.wow | flags_d.robby;
		flags_d.only_samples = flags_d.seawolf2;
		flags_d.plus_samples = flags_d.gorf | flags_d.wow;
	end

	// Flag register, one clock behind the code
	always_ff @(posedge i_clk_sys or posedge i_reset) begin
		if (i_reset) begin
			o_flags <= '0;
		end else begin
			o_flags <= flags_d;
		end
	end

endmodule

// ==== hw/lamp_serializer.sv ====
// Drives an external addressable latch, one changed lamp per write
// Active only for Gorf and Robby Roto; a lamp goes out every 8 clocks at most
`include "astro_macros.svh"

module lamp_serializer (
	input  logic                   i_clk_sys,
	input  logic                   i_reset,
	input  astro_pkg::game_flags_t i_flags,
	input  logic [`LAMP_N-1:0]     i_lamps,
	output astro_pkg::lamp_cmd_t   o_lamp
);

	// Free-running divider and its edge detector
	logic [1:0] div_q;
	logic tick_bit_q;
	logic tick;
	// Lamp states already written to the latch
	logic [`LAMP_N-1:0] sent_q;
	logic [`LAMP_N-1:0] diff;
	// Lowest changed lamp index
	logic [`LAMP_ADDR_W-1:0] sel;
	logic enable;

	assign enable = i_flags.gorf | i_flags.robby;
	assign tick   = div_q[`LAMP_TICK_BIT] & ~tick_bit_q;
	assign diff   = i_lamps ^ sent_q;

	// ==================================================
	// Tick generation
	// ==================================================
	always_ff @(posedge i_clk_sys or posedge i_reset) begin
		if (i_reset) begin
			div_q      <= 2'd0;
			tick_bit_q <= 1'b0;
		end else begin
			div_q      <= div_q + 2'd1;
			tick_bit_q <= div_q[`LAMP_TICK_BIT];
		end
	end

	// Priority pick, scanning down so the lowest index wins
	always_comb begin
		sel = '0;
		for (int i = `LAMP_N - 1; i >= 0; i--) begin
			if (diff[i]) begin
				sel = `LAMP_ADDR_W'(i);
			end
		end
	end

	// ==================================================
	// Latch write sequencing
	// ==================================================
	always_ff @(posedge i_clk_sys or posedge i_reset) begin
		if (i_reset) begin
			o_lamp.addr <= '0;
			o_lamp.data <= 1'b0;
			o_lamp.wr_n <= 1'b1;
			// All ones so lamps that start off get written
			sent_q      <= '1;
		end else if (enable && tick) begin
			if (!o_lamp.wr_n) begin
				// Close the write strobe
				o_lamp.wr_n <= 1'b1;
			end else if (diff != '0) begin
				o_lamp.addr  <= sel;
				o_lamp.data  <= i_lamps[sel];
				o_lamp.wr_n  <= 1'b0;
				sent_q[sel]  <= i_lamps[sel];
			end
		end
	end

endmodule

// ==== src.f ====
+incdir+common
common/astro_pkg.sv
hw/game_config.sv
hw/audio/audio_mixer.sv
hw/audio/cabinet_router.sv
hw/audio/output_select.sv
hw/lamp_serializer.sv
hw/astro_cabinet_top.sv
tb/astro_checker.sv
tb/tb_astro.sv

// ==== tb/astro_checker.sv ====
// Audio is compared one clock after the check strobe; lamp writes are taken on wr_n falls
// Up to 8 latch writes are stored per lamp test
`include "astro_macros.svh"

module astro_checker (
	input  logic                   i_clk_sys,
	input  logic                   i_reset,
	input  astro_pkg::stereo_pcm_t i_audio,
	input  logic                   i_audio_signed,
	input  astro_pkg::lamp_cmd_t   i_lamp,
	input  logic [127:0]           i_name,
	input  logic                   i_audio_check,
	input  astro_pkg::stereo_pcm_t i_exp_audio,
	input  logic                   i_exp_signed,
	input  logic                   i_lamp_open,
	input  logic                   i_lamp_check,
	input  logic [3:0]             i_exp_count,
	input  logic [31:0]            i_exp_writes,
	output int                     o_audio_errors,
	output int                     o_lamp_errors,
	output int                     o_write_count
);
	timeunit 1ns;
	timeprecision 100ps;

	int audio_errors = 0;
	int lamp_errors = 0;
	// Strobe history and the open lamp window
	logic wr_n_q;
	logic window_q;
	// Seen writes as {data, addr} nibbles with the first write lowest
	logic [31:0] seen_q;
	int write_q;

	assign o_audio_errors = audio_errors;
	assign o_lamp_errors  = lamp_errors;
	assign o_write_count  = write_q;

	// ==================================================
	// Audio compare
	// ==================================================
	task automatic compare_audio();
		if (i_audio.left !== i_exp_audio.left) begin
			$display("FAIL %0s left: expected %h actual %h", i_name, i_exp_audio.left,
				i_audio.left);
			audio_errors++;
		end
		if (i_audio.right !== i_exp_audio.right) begin
			$display("FAIL %0s right: expected %h actual %h", i_name, i_exp_audio.right,
				i_audio.right);
			audio_errors++;
		end
		if (i_audio_signed !== i_exp_signed) begin
			$display("FAIL %0s signed flag: expected %b actual %b", i_name, i_exp_signed,
				i_audio_signed);
			audio_errors++;
		end
	endtask

	// ==================================================
	// Lamp write compare
	// ==================================================
	task automatic compare_lamps();
		int n;
		logic [3:0] exp_w;
		logic [3:0] act_w;
		n = (write_q < int'(i_exp_count)) ? write_q : int'(i_exp_count);
		if (write_q < int'(i_exp_count)) begin
			$display("Lamp test %0s saw only %0d of %0d expected latch writes", i_name,
				write_q, i_exp_count);
			lamp_errors++;
		end else if (write_q > int'(i_exp_count)) begin
			$display("FAIL %0s write count: expected %0d actual %0d", i_name, i_exp_count,
				write_q);
			lamp_errors++;
		end
		// Writes must come lowest index first
		for (int i = 0; i < n && i < 8; i++) begin
			exp_w = i_exp_writes[4*i +: 4];
			act_w = seen_q[4*i +: 4];
			if (act_w !== exp_w) begin
				$display("FAIL %0s write %0d addr/data: expected %0d/%b actual %0d/%b",
					i_name, i, exp_w[2:0], exp_w[3], act_w[2:0], act_w[3]);
				lamp_errors++;
			end
		end
	endtask

	always @(posedge i_clk_sys or posedge i_reset) begin
		if (i_reset) begin
			wr_n_q   <= 1'b1;
			window_q <= 1'b0;
			seen_q   <= '0;
			write_q  <= 0;
		end else begin
			wr_n_q <= i_lamp.wr_n;
			if (i_audio_check) begin
				compare_audio();
			end
			if (i_lamp_open) begin
				// New lamp test clears earlier writes
				window_q <= 1'b1;
				seen_q   <= '0;
				write_q  <= 0;
			end else if (wr_n_q && !i_lamp.wr_n) begin
				if (!window_q) begin
					$display("Unexpected lamp latch write to address %0d outside a lamp test",
						i_lamp.addr);
					lamp_errors++;
				end else begin
					if (write_q < 8) begin
						seen_q[4*write_q +: 4] <= {i_lamp.data, i_lamp.addr};
					end
					write_q <= write_q + 1;
				end
			end
			if (i_lamp_check) begin
				compare_lamps();
				window_q <= 1'b0;
			end
		end
	end

endmodule

// ==== tb/astro_golden.txt ====
# A name code dip chip_l chip_r samp_l samp_r speech exp_l exp_r exp_signed (hex)
# L name code lamps count writes; writes are {data,addr} nibbles, first write lowest
A mono_none 00 02 1234 5678 0000 0000 0 1234 1234 0
A mono_ebase 01 02 abcd 0101 0000 0000 0 abcd abcd 0
A robby_stereo 06 02 1111 2222 3333 4444 0 1111 2222 0
A robby_swap 06 00 1111 2222 3333 4444 0 2222 1111 0
A spacezap_swap 03 00 4321 8765 0000 0000 0 4321 4321 0
A seawolf2_samp 02 02 1111 2222 8001 7ffe 0 8001 7ffe 1
A seawolf2_swap 02 00 1111 2222 1234 f00d 0 f00d 1234 1
A gorf_mix 04 02 1000 2000 0400 fc00 0 0a00 0e00 1
A wow_mix 05 02 1000 8000 0400 0000 0 0600 2000 1
A wow_max 05 02 ffff ffff 7fff 8000 0 7ffe ffff 1
A gorf_clip_pos 04 02 ffff ffff 7ffe 7ffe 0 7fff 7fff 1
A gorf_neg_edge 04 02 0000 0000 8000 8000 0 c000 c000 1
A gorf_cab_chip 04 03 8642 fffe 1357 2468 0 4321 7fff 1
A gorf_cab_speech 04 03 8642 fffe 1357 2468 1 1357 7fff 1
A gorf_cab_swap 04 01 8642 fffe 1357 2468 1 7fff 1357 1
A gorf1_mix 07 02 1000 2000 0400 fc00 0 0a00 0e00 1
A gorf1_cab 07 03 0002 0004 aaaa 5555 1 aaaa 0002 1
A wow_cab_ignored 05 03 1000 8000 0400 0000 0 0600 2000 1
L lamp_gorf 04 a5 4 00006431
L lamp_gorf_change 04 a4 1 00000000
L lamp_ebase_off 01 5a 0 00000000
L lamp_gorf1 07 5a 7 07e5cb29
L lamp_robby 06 ff 4 0000fda8

// ==== tb/tb_astro.sv ====
// Runs from the project root and reads tb/astro_golden.txt
// Lamp inputs hold their last pattern, so audio records cause no latch writes
`include "astro_macros.svh"

module tb_astro;
	timeunit 1ns;
	timeprecision 100ps;

	// UUT ports
	logic clk_sys;
	logic reset;
	logic load;
	logic [7:0] code;
	logic [7:0] dip;
	astro_pkg::stereo_pcm_t chip;
	astro_pkg::stereo_pcm_t samp;
	logic speech;
	logic [`LAMP_N-1:0] lamps;
	astro_pkg::stereo_pcm_t audio;
	logic audio_signed;
	astro_pkg::lamp_cmd_t lamp;

	// Expectations for the checker
	logic [127:0] test_name;
	logic audio_check;
	astro_pkg::stereo_pcm_t exp_audio;
	logic exp_signed;
	logic lamp_open;
	logic lamp_check;
	logic [3:0] exp_count;
	logic [31:0] exp_writes;
	int audio_errors;
	int lamp_errors;
	int write_count;
	int format_errors = 0;

	string records[$];
	logic loaded = 1'b0;

	// 4 ns clock
	always #2 clk_sys = ~clk_sys;

	astro_cabinet_top UUT (
		.i_clk_sys      (clk_sys),
		.i_reset        (reset),
		.i_load         (load),
		.i_code         (code),
		.i_dip          (dip),
		.i_chip         (chip),
		.i_samp         (samp),
		.i_speech       (speech),
		.i_lamps        (lamps),
		.o_audio        (audio),
		.o_audio_signed (audio_signed),
		.o_lamp         (lamp)
	);

	astro_checker u_checker (
		.i_clk_sys      (clk_sys),
		.i_reset        (reset),
		.i_audio        (audio),
		.i_audio_signed (audio_signed),
		.i_lamp         (lamp),
		.i_name         (test_name),
		.i_audio_check  (audio_check),
		.i_exp_audio    (exp_audio),
		.i_exp_signed   (exp_signed),
		.i_lamp_open    (lamp_open),
		.i_lamp_check   (lamp_check),
		.i_exp_count    (exp_count),
		.i_exp_writes   (exp_writes),
		.o_audio_errors (audio_errors),
		.o_lamp_errors  (lamp_errors),
		.o_write_count  (write_count)
	);

	// Keep record lines, skipping comments and blank lines
	task automatic read_golden(output logic ok);
		int fd;
		string line;
		fd = $fopen("tb/astro_golden.txt", "r");
		if (fd != 0) begin
			while (!$feof(fd)) begin
				line = "";
				if ($fgets(line, fd) > 0 && line.len() > 1 && line.getc(0) != "#") begin
					records.push_back(line);
				end
			end
			$fclose(fd);
		end
		ok = (records.size() > 0);
	endtask

	task automatic load_game(input logic [7:0] game);
		load <= 1'b1;
		code <= game;
		@(posedge clk_sys);
		load <= 1'b0;
		// Flags settle two clocks after the load edge
		repeat (2) @(posedge clk_sys);
	endtask

	// ==================================================
	// Audio record, vector held 4 clocks
	// ==================================================
	task automatic run_audio(input string line);
		logic [7:0] kind;
		logic [127:0] name;
		logic [7:0] r_code;
		logic [7:0] r_dip;
		logic [15:0] cl, cr, sl, sr, el, er;
		logic r_speech;
		logic r_signed;
		int n;
		n = $sscanf(line, "%s %s %h %h %h %h %h %h %h %h %h %h", kind, name, r_code, r_dip,
			cl, cr, sl, sr, r_speech, el, er, r_signed);
		if (n != 12) begin
			format_errors++;
			$display("Malformed audio record in golden file: %s", line);
		end else begin
			test_name <= name;
			load_game(r_code);
			dip        <= r_dip;
			chip.left  <= cl;
			chip.right <= cr;
			samp.left  <= sl;
			samp.right <= sr;
			speech     <= r_speech;
			exp_audio.left  <= el;
			exp_audio.right <= er;
			exp_signed      <= r_signed;
			repeat (3) @(posedge clk_sys);
			// Compare on the last held cycle
			audio_check <= 1'b1;
			@(posedge clk_sys);
			audio_check <= 1'b0;
		end
	endtask

	// ==================================================
	// Lamp record, wait for the expected writes
	// ==================================================
	task automatic run_lamp(input string line);
		logic [7:0] kind;
		logic [127:0] name;
		logic [7:0] r_code;
		logic [7:0] r_pattern;
		logic [3:0] r_count;
		logic [31:0] r_writes;
		int n;
		int waited;
		n = $sscanf(line, "%s %s %h %h %h %h", kind, name, r_code, r_pattern, r_count,
			r_writes);
		if (n != 6) begin
			format_errors++;
			$display("Malformed lamp record in golden file: %s", line);
		end else begin
			test_name  <= name;
			exp_count  <= r_count;
			exp_writes <= r_writes;
			lamp_open  <= 1'b1;
			load_game(r_code);
			lamp_open <= 1'b0;
			lamps     <= r_pattern;
			waited = 0;
			while (write_count < int'(r_count) && waited < int'(r_count) * 8 + 32) begin
				@(posedge clk_sys);
				waited++;
			end
			// A few more ticks to catch extra writes
			repeat (24) @(posedge clk_sys);
			lamp_check <= 1'b1;
			@(posedge clk_sys);
			lamp_check <= 1'b0;
		end
	endtask

	initial begin
		logic ok;
		clk_sys     = 1'b0;
		reset       = 1'b1;
		load        = 1'b0;
		code        = 8'd0;
		dip         = 8'd0;
		chip        = '0;
		samp        = '0;
		speech      = 1'b0;
		lamps       = '1;
		test_name   = '0;
		audio_check = 1'b0;
		exp_audio   = '0;
		exp_signed  = 1'b0;
		lamp_open   = 1'b0;
		lamp_check  = 1'b0;
		exp_count   = 4'd0;
		exp_writes  = 32'd0;
		read_golden(ok);
		if (!ok) begin
			$display("Golden file tb/astro_golden.txt is missing or holds no records");
			$display("TEST FAILED");
		end else begin
			loaded = 1'b1;
			repeat (3) @(posedge clk_sys);
			reset <= 1'b0;
			@(posedge clk_sys);
			foreach (records[i]) begin
				if (records[i].getc(0) == "A") begin
					run_audio(records[i]);
				end else if (records[i].getc(0) == "L") begin
					run_lamp(records[i]);
				end else begin
					format_errors++;
					$display("Unknown record kind in golden file: %s", records[i]);
				end
			end
			repeat (4) @(posedge clk_sys);
			$display("Errors: audio %0d, lamp %0d, golden file %0d", audio_errors,
				lamp_errors, format_errors);
			if (audio_errors + lamp_errors + format_errors == 0) begin
				$display("TEST PASSED");
			end else begin
				$display("TEST FAILED");
			end
		end
		$finish;
	end

	// Watchdog sized from the record count
	initial begin
		wait (loaded);
		repeat (records.size() * 64 + 200) @(posedge clk_sys);
		$display("Watchdog expired after %0d cycles before all records finished",
			records.size() * 64 + 200);
		$display("TEST FAILED");
		$finish;
	end

endmodule
